// File: Bender.yml
package:
  name: board_io

sources:
  - board_io_pkg.sv
  - converter_io.sv
  - spi_fanout.sv
  - watchdog_kick.sv
  - board_io_top.sv
  - target: test
    files:
      - board_io_sva.sv
      - tb_board_io.sv

// File: board_io_pkg.sv
package board_io_pkg;

   // Converter widths
   localparam int ADC_W = 14;
   localparam int DAC_W = 16;

   // Watchdog counter, kick pin is the top bit
   localparam int WD_BITS = 16;

   // Number of active-low SPI selects
   localparam int SPI_DEVS = 8;

   // Bit position of each device in the select vector
   localparam int SEL_CLK    = 0;   // Clock generator
   localparam int SEL_DAC    = 1;   // Main DAC
   localparam int SEL_TX_DB  = 2;
   localparam int SEL_TX_ADC = 3;
   localparam int SEL_TX_DAC = 4;
   localparam int SEL_RX_DB  = 5;
   localparam int SEL_RX_ADC = 6;
   localparam int SEL_RX_DAC = 7;

   // One ADC sample
   typedef logic [ADC_W-1:0] adc_sample_t;

   // One DAC word
   typedef logic [DAC_W-1:0] dac_sample_t;

   // Active-low chip selects
   typedef logic [SPI_DEVS-1:0] spi_sel_t;

endpackage

// File: board_io_sva.sv
module board_io_sva
(
   input logic                      dsp_clk,
   input logic                      rst_i,
   input board_io_pkg::adc_sample_t adc_a_pin_i, adc_b_pin_i, adc_a_o, adc_b_o,
   input logic                      adc_ovf_a_pin_i, adc_ovf_b_pin_i, adc_ovf_a_o, adc_ovf_b_o,
   input board_io_pkg::dac_sample_t dac_a_i, dac_b_i, dac_a_pin_o, dac_b_pin_o,
   input board_io_pkg::spi_sel_t    spi_sen_i,
   input logic                      sclk_main_o, sdi_main_o, sclk_tx_db_o, sdi_tx_db_o,
   input logic                      sclk_tx_adc_o, sdi_tx_adc_o, sclk_tx_dac_o, sdi_tx_dac_o,
   input logic                      sclk_rx_db_o, sdi_rx_db_o, sclk_rx_adc_o, sdi_rx_adc_o,
   input logic                      sclk_rx_dac_o, sdi_rx_dac_o
);
   timeunit 1ns;
   timeprecision 100ps;
   import board_io_pkg::*;

   logic [6:0] quiet_ok;   // One bit per clock/data pair

   assign quiet_ok[0] = !(spi_sen_i[SEL_CLK] && spi_sen_i[SEL_DAC]) || !(sclk_main_o || sdi_main_o);
   assign quiet_ok[1] = !spi_sen_i[SEL_TX_DB] || !(sclk_tx_db_o || sdi_tx_db_o);
   assign quiet_ok[2] = !spi_sen_i[SEL_TX_ADC] || !(sclk_tx_adc_o || sdi_tx_adc_o);
   assign quiet_ok[3] = !spi_sen_i[SEL_TX_DAC] || !(sclk_tx_dac_o || sdi_tx_dac_o);
   assign quiet_ok[4] = !spi_sen_i[SEL_RX_DB] || !(sclk_rx_db_o || sdi_rx_db_o);
   assign quiet_ok[5] = !spi_sen_i[SEL_RX_ADC] || !(sclk_rx_adc_o || sdi_rx_adc_o);
   assign quiet_ok[6] = !spi_sen_i[SEL_RX_DAC] || !(sclk_rx_dac_o || sdi_rx_dac_o);

   // Two register stages with the channels crossed
   adc_path_a: assert property (@(posedge dsp_clk) disable iff (rst_i)
      !$past(rst_i) && !$past(rst_i, 2) |->
         adc_a_o == $past(adc_b_pin_i, 2) && adc_ovf_a_o == $past(adc_ovf_b_pin_i, 2))
      else $error("ADC A output does not carry the B pins from two cycles back");

   adc_path_b: assert property (@(posedge dsp_clk) disable iff (rst_i)
      !$past(rst_i) && !$past(rst_i, 2) |->
         adc_b_o == $past(adc_a_pin_i, 2) && adc_ovf_b_o == $past(adc_ovf_a_pin_i, 2))
      else $error("ADC B output does not carry the A pins from two cycles back");

   dac_path: assert property (@(posedge dsp_clk) disable iff (rst_i)
      !$past(rst_i) |-> dac_a_pin_o == ~$past(dac_b_i) && dac_b_pin_o == $past(dac_a_i))
      else $error("DAC pins do not match the crossed words from one cycle back");

   spi_quiet: assert property (@(posedge dsp_clk) &quiet_ok)
      else $error("An unselected SPI clock or data pin is not quiet");

endmodule

bind board_io_top board_io_sva board_io_sva_i (.*);

// File: board_io_top.sv
module board_io_top
(
   input  logic                      dsp_clk,
   input  logic                      rst_i,

   // ADC pins and core side
   input  board_io_pkg::adc_sample_t adc_a_pin_i,
   input  board_io_pkg::adc_sample_t adc_b_pin_i,
   input  logic                      adc_ovf_a_pin_i,
   input  logic                      adc_ovf_b_pin_i,
   input  logic                      adc_on_a_i,
   input  logic                      adc_on_b_i,
   input  logic                      adc_oe_a_i,
   input  logic                      adc_oe_b_i,
   output board_io_pkg::adc_sample_t adc_a_o,
   output board_io_pkg::adc_sample_t adc_b_o,
   output logic                      adc_ovf_a_o,
   output logic                      adc_ovf_b_o,
   output logic                      adc_pdn_a_o,
   output logic                      adc_pdn_b_o,
   output logic                      adc_oen_a_o,
   output logic                      adc_oen_b_o,

   // DAC
   input  board_io_pkg::dac_sample_t dac_a_i,
   input  board_io_pkg::dac_sample_t dac_b_i,
   output board_io_pkg::dac_sample_t dac_a_pin_o,
   output board_io_pkg::dac_sample_t dac_b_pin_o,

   // SPI master side
   input  logic                      spi_sclk_i,
   input  logic                      spi_mosi_i,
   input  board_io_pkg::spi_sel_t    spi_sen_i,
   output logic                      spi_miso_o,

   // SPI device side
   input  logic                      sdo_main_i,
   input  logic                      sdo_tx_db_i,
   input  logic                      sdo_tx_adc_i,
   input  logic                      sdo_rx_db_i,
   input  logic                      sdo_rx_adc_i,
   output board_io_pkg::spi_sel_t    sen_o,
   output logic                      sclk_main_o,
   output logic                      sdi_main_o,
   output logic                      sclk_tx_db_o,
   output logic                      sdi_tx_db_o,
   output logic                      sclk_tx_adc_o,
   output logic                      sdi_tx_adc_o,
   output logic                      sclk_tx_dac_o,
   output logic                      sdi_tx_dac_o,
   output logic                      sclk_rx_db_o,
   output logic                      sdi_rx_db_o,
   output logic                      sclk_rx_adc_o,
   output logic                      sdi_rx_adc_o,
   output logic                      sclk_rx_dac_o,
   output logic                      sdi_rx_dac_o,

   // Watchdog
   input  logic                      config_success_i,
   output logic                      wdi_o
);

   converter_io converter_io_i
   (
      .dsp_clk         (dsp_clk),
      .rst_i           (rst_i),
      .adc_a_pin_i     (adc_a_pin_i),
      .adc_b_pin_i     (adc_b_pin_i),
      .adc_ovf_a_pin_i (adc_ovf_a_pin_i),
      .adc_ovf_b_pin_i (adc_ovf_b_pin_i),
      .adc_on_a_i      (adc_on_a_i),
      .adc_on_b_i      (adc_on_b_i),
      .adc_oe_a_i      (adc_oe_a_i),
      .adc_oe_b_i      (adc_oe_b_i),
      .dac_a_i         (dac_a_i),
      .dac_b_i         (dac_b_i),
      .adc_a_o         (adc_a_o),
      .adc_b_o         (adc_b_o),
      .adc_ovf_a_o     (adc_ovf_a_o),
      .adc_ovf_b_o     (adc_ovf_b_o),
      .adc_pdn_a_o     (adc_pdn_a_o),
      .adc_pdn_b_o     (adc_pdn_b_o),
      .adc_oen_a_o     (adc_oen_a_o),
      .adc_oen_b_o     (adc_oen_b_o),
      .dac_a_pin_o     (dac_a_pin_o),
      .dac_b_pin_o     (dac_b_pin_o)
   );

   // Purely combinational, no clock needed
   spi_fanout spi_fanout_i
   (
      .spi_sclk_i    (spi_sclk_i),
      .spi_mosi_i    (spi_mosi_i),
      .spi_sen_i     (spi_sen_i),
      .spi_miso_o    (spi_miso_o),
      .sdo_main_i    (sdo_main_i),
      .sdo_tx_db_i   (sdo_tx_db_i),
      .sdo_tx_adc_i  (sdo_tx_adc_i),
      .sdo_rx_db_i   (sdo_rx_db_i),
      .sdo_rx_adc_i  (sdo_rx_adc_i),
      .sen_o         (sen_o),
      .sclk_main_o   (sclk_main_o),
      .sdi_main_o    (sdi_main_o),
      .sclk_tx_db_o  (sclk_tx_db_o),
      .sdi_tx_db_o   (sdi_tx_db_o),
      .sclk_tx_adc_o (sclk_tx_adc_o),
      .sdi_tx_adc_o  (sdi_tx_adc_o),
      .sclk_tx_dac_o (sclk_tx_dac_o),
      .sdi_tx_dac_o  (sdi_tx_dac_o),
      .sclk_rx_db_o  (sclk_rx_db_o),
      .sdi_rx_db_o   (sdi_rx_db_o),
      .sclk_rx_adc_o (sclk_rx_adc_o),
      .sdi_rx_adc_o  (sdi_rx_adc_o),
      .sclk_rx_dac_o (sclk_rx_dac_o),
      .sdi_rx_dac_o  (sdi_rx_dac_o)
   );

   watchdog_kick watchdog_kick_i
   (
      .dsp_clk          (dsp_clk),
      .rst_i            (rst_i),
      .config_success_i (config_success_i),
      .wdi_o            (wdi_o)
   );

endmodule

// File: converter_io.sv
module converter_io
(
   input  logic                      dsp_clk,
   input  logic                      rst_i,

   // ADC pins
   input  board_io_pkg::adc_sample_t adc_a_pin_i,
   input  board_io_pkg::adc_sample_t adc_b_pin_i,
   input  logic                      adc_ovf_a_pin_i,
   input  logic                      adc_ovf_b_pin_i,

   // Converter requests from the core, active high
   input  logic                      adc_on_a_i,
   input  logic                      adc_on_b_i,
   input  logic                      adc_oe_a_i,
   input  logic                      adc_oe_b_i,

   // DAC words from the core
   input  board_io_pkg::dac_sample_t dac_a_i,
   input  board_io_pkg::dac_sample_t dac_b_i,

   // Captured ADC data towards the core
   output board_io_pkg::adc_sample_t adc_a_o,
   output board_io_pkg::adc_sample_t adc_b_o,
   output logic                      adc_ovf_a_o,
   output logic                      adc_ovf_b_o,

   // Active-low converter control pins
   output logic                      adc_pdn_a_o,
   output logic                      adc_pdn_b_o,
   output logic                      adc_oen_a_o,
   output logic                      adc_oen_b_o,

   // DAC pins
   output board_io_pkg::dac_sample_t dac_a_pin_o,
   output board_io_pkg::dac_sample_t dac_b_pin_o
);
   import board_io_pkg::*;

   adc_sample_t adc_a_q1;   // First stage, channels already swapped
   adc_sample_t adc_b_q1;
   logic        adc_ovf_a_q1;
   logic        adc_ovf_b_q1;

   // Control pins are plain inversions of the requests
   assign adc_pdn_a_o = ~adc_on_a_i;
   assign adc_pdn_b_o = ~adc_on_b_i;
   assign adc_oen_a_o = ~adc_oe_a_i;
   assign adc_oen_b_o = ~adc_oe_b_i;

   // ADC channels are crossed on the board, undo it at capture
   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         adc_a_q1     <= '0;
         adc_b_q1     <= '0;
         adc_ovf_a_q1 <= 1'b0;
         adc_ovf_b_q1 <= 1'b0;
      end
      else
      begin
         adc_a_q1     <= adc_b_pin_i;
         adc_b_q1     <= adc_a_pin_i;
         adc_ovf_a_q1 <= adc_ovf_b_pin_i;
         adc_ovf_b_q1 <= adc_ovf_a_pin_i;
      end
   end

   // Second stage drives the core side
   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         adc_a_o     <= '0;
         adc_b_o     <= '0;
         adc_ovf_a_o <= 1'b0;
         adc_ovf_b_o <= 1'b0;
      end
      else
      begin
         adc_a_o     <= adc_a_q1;
         adc_b_o     <= adc_b_q1;
         adc_ovf_a_o <= adc_ovf_a_q1;
         adc_ovf_b_o <= adc_ovf_b_q1;
      end
   end

   // DAC channels are also crossed, and DAC A is wired inverted
   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         dac_a_pin_o <= '0;
         dac_b_pin_o <= '0;
      end
      else
      begin
         dac_a_pin_o <= ~dac_b_i;
         dac_b_pin_o <= dac_a_i;
      end
   end

endmodule

// File: flist.f
board_io_pkg.sv
converter_io.sv
spi_fanout.sv
watchdog_kick.sv
board_io_top.sv
board_io_sva.sv
tb_board_io.sv

// File: spi_fanout.sv
module spi_fanout
(
   // Shared SPI master
   input  logic                   spi_sclk_i,
   input  logic                   spi_mosi_i,
   input  board_io_pkg::spi_sel_t spi_sen_i,
   output logic                   spi_miso_o,

   // Readback lines from the devices
   input  logic                   sdo_main_i,   // Clock generator and main DAC
   input  logic                   sdo_tx_db_i,
   input  logic                   sdo_tx_adc_i,
   input  logic                   sdo_rx_db_i,
   input  logic                   sdo_rx_adc_i,

   // Select pins
   output board_io_pkg::spi_sel_t sen_o,

   // Per-device clock and data pins
   output logic                   sclk_main_o,
   output logic                   sdi_main_o,
   output logic                   sclk_tx_db_o,
   output logic                   sdi_tx_db_o,
   output logic                   sclk_tx_adc_o,
   output logic                   sdi_tx_adc_o,
   output logic                   sclk_tx_dac_o,
   output logic                   sdi_tx_dac_o,
   output logic                   sclk_rx_db_o,
   output logic                   sdi_rx_db_o,
   output logic                   sclk_rx_adc_o,
   output logic                   sdi_rx_adc_o,
   output logic                   sclk_rx_dac_o,
   output logic                   sdi_rx_dac_o
);
   import board_io_pkg::*;

   logic main_open;   // Clock gen and main DAC share one pair

   assign sen_o = spi_sen_i;

   assign main_open = ~spi_sen_i[SEL_CLK] | ~spi_sen_i[SEL_DAC];

   // Unselected devices see quiet lines
   assign {sclk_main_o, sdi_main_o}     = main_open ? {spi_sclk_i, spi_mosi_i} : 2'b00;
   assign {sclk_tx_db_o, sdi_tx_db_o}   =
      ~spi_sen_i[SEL_TX_DB] ? {spi_sclk_i, spi_mosi_i} : 2'b00;
   assign {sclk_tx_adc_o, sdi_tx_adc_o} =
      ~spi_sen_i[SEL_TX_ADC] ? {spi_sclk_i, spi_mosi_i} : 2'b00;
   assign {sclk_tx_dac_o, sdi_tx_dac_o} =
      ~spi_sen_i[SEL_TX_DAC] ? {spi_sclk_i, spi_mosi_i} : 2'b00;
   assign {sclk_rx_db_o, sdi_rx_db_o}   =
      ~spi_sen_i[SEL_RX_DB] ? {spi_sclk_i, spi_mosi_i} : 2'b00;
   assign {sclk_rx_adc_o, sdi_rx_adc_o} =
      ~spi_sen_i[SEL_RX_ADC] ? {spi_sclk_i, spi_mosi_i} : 2'b00;
   assign {sclk_rx_dac_o, sdi_rx_dac_o} =
      ~spi_sen_i[SEL_RX_DAC] ? {spi_sclk_i, spi_mosi_i} : 2'b00;

   // DACs on the daughterboards have no readback
   assign spi_miso_o = (~spi_sen_i[SEL_CLK]    & sdo_main_i)   |
                       (~spi_sen_i[SEL_DAC]    & sdo_main_i)   |
                       (~spi_sen_i[SEL_TX_DB]  & sdo_tx_db_i)  |
                       (~spi_sen_i[SEL_TX_ADC] & sdo_tx_adc_i) |
                       (~spi_sen_i[SEL_RX_DB]  & sdo_rx_db_i)  |
                       (~spi_sen_i[SEL_RX_ADC] & sdo_rx_adc_i);

endmodule

// File: tb_board_io.sv
module tb_board_io;
   timeunit 1ns;
   timeprecision 100ps;
   import board_io_pkg::*;

   logic        dsp_clk = 1'b0;
   logic        rst_i;
   adc_sample_t adc_a_pin_i, adc_b_pin_i, adc_a_o, adc_b_o;
   logic        adc_ovf_a_pin_i, adc_ovf_b_pin_i, adc_ovf_a_o, adc_ovf_b_o;
   logic        adc_on_a_i, adc_on_b_i, adc_oe_a_i, adc_oe_b_i;
   logic        adc_pdn_a_o, adc_pdn_b_o, adc_oen_a_o, adc_oen_b_o;
   dac_sample_t dac_a_i, dac_b_i, dac_a_pin_o, dac_b_pin_o;
   logic        spi_sclk_i, spi_mosi_i, spi_miso_o;
   spi_sel_t    spi_sen_i, sen_o;
   logic        sdo_main_i, sdo_tx_db_i, sdo_tx_adc_i, sdo_rx_db_i, sdo_rx_adc_i;
   logic        sclk_main_o, sdi_main_o, sclk_tx_db_o, sdi_tx_db_o;
   logic        sclk_tx_adc_o, sdi_tx_adc_o, sclk_tx_dac_o, sdi_tx_dac_o;
   logic        sclk_rx_db_o, sdi_rx_db_o, sclk_rx_adc_o, sdi_rx_adc_o;
   logic        sclk_rx_dac_o, sdi_rx_dac_o;
   logic        config_success_i, wdi_o;

   int          err_cnt = 0;
   int          timeout_cnt = 0;
   logic [31:0] lfsr_state = 32'h6617_43a7;

   board_io_top board_io_top_i (.*);

   always #2 dsp_clk = ~dsp_clk;   // 4 ns period

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic next_bit();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_word(input int nbits);
      logic [31:0] w;
      w = '0;
      for (int i = 0; i < nbits; i++)
      begin
         w = {w[30:0], next_bit()};
      end
      return w;
   endfunction

   task automatic check_adc(input string name, input adc_sample_t got, input adc_sample_t exp);
      if (got !== exp)
      begin
         err_cnt++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_dac(input string name, input dac_sample_t got, input dac_sample_t exp);
      if (got !== exp)
      begin
         err_cnt++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_sel(input string name, input spi_sel_t got, input spi_sel_t exp);
      if (got !== exp)
      begin
         err_cnt++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         err_cnt++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic reset_state();
      rst_i = 1'b1;
      config_success_i = 1'b1;   // Counter held by reset alone
      adc_a_pin_i = '1;
      adc_b_pin_i = '1;
      {adc_ovf_a_pin_i, adc_ovf_b_pin_i} = 2'b11;
      dac_a_i = '1;   // Both DAC pins would show all ones
      dac_b_i = '0;
      repeat (10) @(negedge dsp_clk);
      rst_i = 1'b0;
      config_success_i = 1'b0;
      check_dac("dac_a_pin_o", dac_a_pin_o, '0);
      check_dac("dac_b_pin_o", dac_b_pin_o, '0);
      check_adc("adc_a_o", adc_a_o, '0);
      check_adc("adc_b_o", adc_b_o, '0);
      check_bit("adc_ovf_a_o", adc_ovf_a_o, 1'b0);
      check_bit("adc_ovf_b_o", adc_ovf_b_o, 1'b0);
      check_bit("wdi_o", wdi_o, 1'b0);
   endtask

   task automatic adc_capture();
      adc_sample_t pa [40];
      adc_sample_t pb [40];
      logic        oa [40];
      logic        ob [40];
      for (int i = 0; i < 40; i++)
      begin
         @(negedge dsp_clk);
         if (i >= 2)   // Outputs show the crossed pins from two cycles back
         begin
            check_adc("adc_a_o", adc_a_o, pb[i-2]);
            check_adc("adc_b_o", adc_b_o, pa[i-2]);
            check_bit("adc_ovf_a_o", adc_ovf_a_o, ob[i-2]);
            check_bit("adc_ovf_b_o", adc_ovf_b_o, oa[i-2]);
         end
         pa[i] = adc_sample_t'(rand_word(ADC_W));
         pb[i] = adc_sample_t'(rand_word(ADC_W));
         oa[i] = next_bit();
         ob[i] = next_bit();
         adc_a_pin_i = pa[i];
         adc_b_pin_i = pb[i];
         adc_ovf_a_pin_i = oa[i];
         adc_ovf_b_pin_i = ob[i];
      end
   endtask

   task automatic dac_drive();
      dac_sample_t prev_a;
      dac_sample_t prev_b;
      for (int i = 0; i < 30; i++)
      begin
         @(negedge dsp_clk);
         if (i > 0)
         begin
            check_dac("dac_a_pin_o", dac_a_pin_o, ~prev_b);
            check_dac("dac_b_pin_o", dac_b_pin_o, prev_a);
         end
         prev_a = dac_sample_t'(rand_word(DAC_W));
         prev_b = dac_sample_t'(rand_word(DAC_W));
         dac_a_i = prev_a;
         dac_b_i = prev_b;
      end
   endtask

   task automatic converter_control();
      for (int i = 0; i < 16; i++)
      begin
         @(negedge dsp_clk);
         {adc_on_a_i, adc_on_b_i, adc_oe_a_i, adc_oe_b_i} = i[3:0];
         #1;
         check_bit("adc_pdn_a_o", adc_pdn_a_o, !i[3]);
         check_bit("adc_pdn_b_o", adc_pdn_b_o, !i[2]);
         check_bit("adc_oen_a_o", adc_oen_a_o, !i[1]);
         check_bit("adc_oen_b_o", adc_oen_b_o, !i[0]);
      end
   endtask

   task automatic gated_pair(input string dev, input logic sclk, input logic sdi, input logic open);
      check_bit({"sclk_", dev, "_o"}, sclk, open & spi_sclk_i);
      check_bit({"sdi_", dev, "_o"}, sdi, open & spi_mosi_i);
   endtask

   task automatic spi_gating();
      logic [6:0] open;   // main tx_db tx_adc tx_dac rx_db rx_adc rx_dac
      logic       exp_miso;
      for (int dev = 0; dev <= SPI_DEVS; dev++)   // Last pass selects nothing
      begin
         for (int n = 0; n < 4; n++)
         begin
            @(negedge dsp_clk);
            spi_sen_i = '1;
            if (dev < SPI_DEVS)
            begin
               spi_sen_i[dev] = 1'b0;
            end
            {spi_sclk_i, spi_mosi_i} = 2'(rand_word(2));
            {sdo_main_i, sdo_tx_db_i, sdo_tx_adc_i, sdo_rx_db_i, sdo_rx_adc_i} = 5'(rand_word(5));
            #1;
            open = '0;
            exp_miso = 1'b0;
            case (dev)
               SEL_CLK, SEL_DAC: {open[0], exp_miso} = {1'b1, sdo_main_i};
               SEL_TX_DB:        {open[1], exp_miso} = {1'b1, sdo_tx_db_i};
               SEL_TX_ADC:       {open[2], exp_miso} = {1'b1, sdo_tx_adc_i};
               SEL_TX_DAC:       open[3] = 1'b1;   // No readback line
               SEL_RX_DB:        {open[4], exp_miso} = {1'b1, sdo_rx_db_i};
               SEL_RX_ADC:       {open[5], exp_miso} = {1'b1, sdo_rx_adc_i};
               SEL_RX_DAC:       open[6] = 1'b1;
               default:          open = '0;
            endcase
            gated_pair("main", sclk_main_o, sdi_main_o, open[0]);
            gated_pair("tx_db", sclk_tx_db_o, sdi_tx_db_o, open[1]);
            gated_pair("tx_adc", sclk_tx_adc_o, sdi_tx_adc_o, open[2]);
            gated_pair("tx_dac", sclk_tx_dac_o, sdi_tx_dac_o, open[3]);
            gated_pair("rx_db", sclk_rx_db_o, sdi_rx_db_o, open[4]);
            gated_pair("rx_adc", sclk_rx_adc_o, sdi_rx_adc_o, open[5]);
            gated_pair("rx_dac", sclk_rx_dac_o, sdi_rx_dac_o, open[6]);
            check_bit("spi_miso_o", spi_miso_o, exp_miso);
            check_sel("sen_o", sen_o, spi_sen_i);
         end
      end
      @(negedge dsp_clk);
      spi_sen_i = '1;
   endtask

   // Counts falling edges until wdi_o reaches the level
   task automatic wait_wdi(input logic level, input int expected);
      int cycles;
      cycles = 0;
      while (wdi_o !== level && cycles < expected + 100)
      begin
         @(negedge dsp_clk);
         cycles++;
      end
      if (wdi_o !== level)
      begin
         timeout_cnt++;
         $display("Timeout: wdi_o did not reach %0b within %0d cycles", level, expected + 100);
      end
      else if (cycles != expected)
      begin
         err_cnt++;
         $display("[FAIL] wdi_o edge after %h cycles expected %h", cycles, expected);
      end
   endtask

   task automatic watchdog_run();
      for (int i = 0; i < 40000; i++)
      begin
         @(negedge dsp_clk);
         check_bit("wdi_o", wdi_o, 1'b0);
      end
      config_success_i = 1'b1;
      wait_wdi(1'b1, 32768);
      wait_wdi(1'b0, 32768);
      wait_wdi(1'b1, 32768);
      config_success_i = 1'b0;   // Counter clears on the next edge
      @(negedge dsp_clk);
      check_bit("wdi_o", wdi_o, 1'b0);
   endtask

   initial
   begin
      rst_i = 1'b1;
      {adc_a_pin_i, adc_b_pin_i, adc_ovf_a_pin_i, adc_ovf_b_pin_i} = '0;
      {adc_on_a_i, adc_on_b_i, adc_oe_a_i, adc_oe_b_i} = '0;
      {dac_a_i, dac_b_i} = '0;
      {spi_sclk_i, spi_mosi_i} = 2'b00;
      spi_sen_i = '1;
      {sdo_main_i, sdo_tx_db_i, sdo_tx_adc_i, sdo_rx_db_i, sdo_rx_adc_i} = '0;
      config_success_i = 1'b0;
      reset_state();
      adc_capture();
      dac_drive();
      converter_control();
      spi_gating();
      watchdog_run();
      $display("Run complete: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
      if (err_cnt == 0 && timeout_cnt == 0)
      begin
         $display("*** PASSED ***");
      end
      else
      begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: watchdog_kick.sv
module watchdog_kick
(
   input  logic dsp_clk,
   input  logic rst_i,
   input  logic config_success_i,
   output logic wdi_o
);
   import board_io_pkg::*;

   logic [WD_BITS-1:0] wd_cnt;

   // Held at zero until the FPGA reports good configuration
   always_ff @(posedge dsp_clk)
   begin
      if (rst_i || !config_success_i)
      begin
         wd_cnt <= '0;
      end
      else
      begin
         wd_cnt <= wd_cnt + 1'b1;   // Free running, wraps
      end
   end

   // Top bit toggles slowly enough for the external supervisor
   assign wdi_o = wd_cnt[WD_BITS-1];

endmodule
